// File: hw/pll_drp_consts.svh
`ifndef PLL_DRP_CONSTS_SVH
`define PLL_DRP_CONSTS_SVH

// ********************
// sizes
// ********************

// clock outputs touched per sequence
`define PLL_NUM_CLKOUT 6
// index of one output, wide enough for 0..5
`define CLKOUT_IDX_W 3
`define DRP_ADDR_W 5
`define DRP_DATA_W 16
`define CLKOUT_DIV_W 8

// ********************
// count word layout
// ********************

// width of the high and low time fields
`define COUNT_TIME_W 6
`define CW_NOCOUNT_BIT 12
`define CW_EDGE_BIT 13

// ********************
// drp map and limits
// ********************

// output i sits at base + i
`define DRP_CLKOUT_BASE 5'h08
// bits kept from the read value
`define DRP_KEEP_MASK 16'hC000
`define CLKOUT_DIV_MAX 126

`endif

// File: hw/pll_drp_pkg.sv
`include "pll_drp_consts.svh"

// shared types for the pll drp reconfiguration logic
package pll_drp_pkg;

   // ********************
   // drp port
   // ********************

   // register address on the drp port
   typedef logic [`DRP_ADDR_W-1:0] drp_addr_t;

   // one drp data word, read or write
   typedef logic [`DRP_DATA_W-1:0] drp_data_t;

   // ********************
   // clock outputs
   // ********************

   // raw divide setting for one output
   typedef logic [`CLKOUT_DIV_W-1:0] clkout_div_t;

   // encoded count word, same width as drp data
   // layout: [5:0] low time, [11:6] high time, [12] nocount, [13] edge
   typedef logic [`DRP_DATA_W-1:0] count_word_t;

   // which output / which register in the table
   typedef logic [`CLKOUT_IDX_W-1:0] clkout_idx_t;

endpackage

// File: hw/clkout_count_encoder.sv
`timescale 1ns/1ns
`include "pll_drp_consts.svh"

// holds six divide settings and turns each into a drp count word
module clkout_count_encoder (
   input  logic                     SCLK,
   input  logic                     RST,
   input  logic                     capture,
   input  pll_drp_pkg::clkout_div_t divides     [`PLL_NUM_CLKOUT],
   output pll_drp_pkg::count_word_t count_words [`PLL_NUM_CLKOUT]
);
   import pll_drp_pkg::*;

   localparam int time_w = `COUNT_TIME_W;     // high / low field width
   localparam clkout_div_t div_max = clkout_div_t'(`CLKOUT_DIV_MAX);
   localparam clkout_div_t div_one = clkout_div_t'(1);

   clkout_div_t div_q [`PLL_NUM_CLKOUT];      // held divides, already legal

   // ********************
   // input range fix
   // ********************
   function automatic clkout_div_t clamp_div(input clkout_div_t d);
      clkout_div_t r;
      if (d == '0) begin
         r = div_one;                         // 0 makes no sense, run as bypass
      end else if (d > div_max) begin
         r = div_max;                         // saturate
      end else begin
         r = d;
      end
      return r;
   endfunction

   // ********************
   // divide to count word
   // ********************
   function automatic count_word_t encode_div(input clkout_div_t d);
      clkout_div_t hi;
      clkout_div_t lo;
      count_word_t w;
      hi = d >> 1;                            // high time, rounded down
      lo = d - hi;                            // low time takes the odd cycle
      w  = '0;
      if (d == div_one) begin
         // divide by one bypasses the counter
         w[`CW_NOCOUNT_BIT] = 1'b1;
         hi = div_one;
         lo = div_one;
      end
      w[`CW_EDGE_BIT] = d[0] && (d != div_one); // odd divide, half cycle edge
      w[2*time_w-1:time_w] = hi[time_w-1:0];
      w[time_w-1:0] = lo[time_w-1:0];
      return w;                               // bits 15:14 stay zero
   endfunction

   // capture all six at once, reset value is a legal divide
   always_ff @(posedge SCLK) begin
      if (RST) begin
         for (int i = 0; i < `PLL_NUM_CLKOUT; i++) begin
            div_q[i] <= div_one;
         end
      end else if (capture) begin
         for (int i = 0; i < `PLL_NUM_CLKOUT; i++) begin
            div_q[i] <= clamp_div(divides[i]);
         end
      end
   end

   // words follow the held divides, valid the cycle after capture
   always_comb begin
      for (int i = 0; i < `PLL_NUM_CLKOUT; i++) begin
         count_words[i] = encode_div(div_q[i]);
      end
   end

endmodule

// File: hw/drp_rmw_sequencer.sv
`timescale 1ns/1ns
`include "pll_drp_consts.svh"

// top control: lock wait, ready pulse, pll reset and the register walk
module drp_rmw_sequencer (
   input  logic                     SCLK,
   input  logic                     RST,
   input  logic                     SEN,
   input  logic                     LOCKED,
   output logic                     SRDY,
   output logic                     RST_PLL,
   output logic                     capture,
   input  pll_drp_pkg::count_word_t count_words [`PLL_NUM_CLKOUT],
   output logic                     start,
   output pll_drp_pkg::drp_addr_t   addr,
   output pll_drp_pkg::count_word_t set_word,
   input  logic                     done
);
   import pll_drp_pkg::*;

   // ********************
   // states
   // ********************
   typedef enum logic [2:0] {
      s_restart,     // after reset, release the pll
      s_wait_lock,   // wait for LOCKED, then SRDY
      s_wait_start,  // idle-ready, only here SEN counts
      s_capture,     // latch divides into the encoder
      s_next,        // start one rmw on the current register
      s_run          // rmw in flight, wait for done
   } state_t;

   localparam clkout_idx_t last_idx = clkout_idx_t'(`PLL_NUM_CLKOUT - 1);
   localparam drp_addr_t base_addr = `DRP_CLKOUT_BASE;

   state_t      state;
   clkout_idx_t idx;                          // register being worked on

   // ********************
   // state register
   // ********************
   always_ff @(posedge SCLK) begin
      if (RST) begin
         state   <= s_restart;
         idx     <= '0;
         SRDY    <= 1'b0;
         RST_PLL <= 1'b1;                     // pll held in reset
      end else begin
         SRDY <= 1'b0;                        // one cycle pulse
         case (state)
            s_restart: begin
               RST_PLL <= 1'b0;               // falls one cycle after RST
               idx     <= '0;
               state   <= s_wait_lock;
            end

            s_wait_lock: begin
               RST_PLL <= 1'b0;
               if (LOCKED) begin
                  SRDY  <= 1'b1;              // ready on first lock seen
                  state <= s_wait_start;
               end
            end

            s_wait_start: begin
               if (SEN) begin
                  state <= s_capture;
               end
            end

            s_capture: begin
               idx   <= '0;                   // walk starts at output 0
               state <= s_next;
            end

            s_next: begin
               // rises with the first DEN, stays up over the whole walk
               RST_PLL <= 1'b1;
               state   <= s_run;
            end

            s_run: begin
               if (done) begin
                  if (idx == last_idx) begin
                     RST_PLL <= 1'b0;         // table done, let pll relock
                     state   <= s_wait_lock;
                  end else begin
                     idx   <= idx + 3'd1;
                     state <= s_next;
                  end
               end
            end

            default: begin
               state <= s_restart;
            end
         endcase
      end
   end

   // ********************
   // decoded outputs
   // ********************
   assign capture  = (state == s_capture);     // cycle after accepted SEN
   assign start    = (state == s_next);        // one per register

   // address and word follow the index, stable while the engine runs
   assign addr     = base_addr + drp_addr_t'(idx);
   assign set_word = count_words[idx];

endmodule

// File: hw/drp_rmw_engine.sv
`timescale 1ns/1ns
`include "pll_drp_consts.svh"

// one read-modify-write on the drp port
module drp_rmw_engine (
   input  logic                     SCLK,
   input  logic                     RST,
   input  logic                     start,
   input  pll_drp_pkg::drp_addr_t   addr,
   input  pll_drp_pkg::count_word_t set_word,
   output logic                     done,
   input  pll_drp_pkg::drp_data_t   DO,
   input  logic                     DRDY,
   output logic                     DEN,
   output logic                     DWE,
   output pll_drp_pkg::drp_addr_t   DADDR,
   output pll_drp_pkg::drp_data_t   DI
);
   import pll_drp_pkg::*;

   typedef enum logic [2:0] {
      s_idle,
      s_read,        // DEN for the read
      s_wait_rd,     // wait for read DRDY
      s_mask,        // keep protected bits
      s_merge,       // or in the new count word
      s_write,       // DEN + DWE
      s_wait_wr      // wait for write DRDY
   } state_t;

   localparam drp_data_t keep_mask = `DRP_KEEP_MASK;

   state_t state;

   // ********************
   // control
   // ********************
   always_ff @(posedge SCLK) begin
      if (RST) begin
         state <= s_idle;
         done  <= 1'b0;
      end else begin
         done <= 1'b0;
         case (state)
            s_idle:    if (start) state <= s_read;
            s_read:    state <= s_wait_rd;     // single cycle strobe
            s_wait_rd: if (DRDY) state <= s_mask;
            s_mask:    state <= s_merge;
            s_merge:   state <= s_write;
            s_write:   state <= s_wait_wr;
            s_wait_wr: begin
               if (DRDY) begin
                  done  <= 1'b1;              // write acknowledged
                  state <= s_idle;
               end
            end
            default:   state <= s_idle;
         endcase
      end
   end

   // ********************
   // address and data path
   // ********************
   always_ff @(posedge SCLK) begin
      if (state == s_idle && start) begin
         DADDR <= addr;                       // held for read and write
      end
      case (state)
         s_wait_rd: if (DRDY) DI <= DO;       // read value
         s_mask:    DI <= DI & keep_mask;
         s_merge:   DI <= DI | drp_data_t'(set_word);
         default:   DI <= DI;
      endcase
   end

   // strobes straight from the state, one cycle each
   assign DEN = (state == s_read) || (state == s_write);
   assign DWE = (state == s_write);

endmodule

// File: hw/pll_drp_reconfig.sv
`timescale 1ns/1ns
`include "pll_drp_consts.svh"

// pll drp reconfiguration controller, top level
module pll_drp_reconfig (
   input  logic                     SCLK,
   input  logic                     RST,
   input  logic                     SEN,
   output logic                     SRDY,
   input  pll_drp_pkg::clkout_div_t clkout0_divide,
   input  pll_drp_pkg::clkout_div_t clkout1_divide,
   input  pll_drp_pkg::clkout_div_t clkout2_divide,
   input  pll_drp_pkg::clkout_div_t clkout3_divide,
   input  pll_drp_pkg::clkout_div_t clkout4_divide,
   input  pll_drp_pkg::clkout_div_t clkout5_divide,
   input  pll_drp_pkg::drp_data_t   DO,
   input  logic                     DRDY,
   input  logic                     LOCKED,
   output logic                     DWE,
   output logic                     DEN,
   output pll_drp_pkg::drp_addr_t   DADDR,
   output pll_drp_pkg::drp_data_t   DI,
   output logic                     DCLK,
   output logic                     RST_PLL
);
   import pll_drp_pkg::*;

   clkout_div_t divides     [`PLL_NUM_CLKOUT];  // loose inputs as one array
   count_word_t count_words [`PLL_NUM_CLKOUT];
   logic        capture;
   logic        start;
   logic        done;
   drp_addr_t   addr;
   count_word_t set_word;

   assign divides[0] = clkout0_divide;
   assign divides[1] = clkout1_divide;
   assign divides[2] = clkout2_divide;
   assign divides[3] = clkout3_divide;
   assign divides[4] = clkout4_divide;
   assign divides[5] = clkout5_divide;

   assign DCLK = SCLK;                          // drp runs on the control clock

   // ********************
   // blocks
   // ********************
   clkout_count_encoder clkout_count_encoder_inst (
      .SCLK, .RST, .capture, .divides, .count_words
   );

   drp_rmw_sequencer drp_rmw_sequencer_inst (
      .SCLK, .RST, .SEN, .LOCKED, .SRDY, .RST_PLL, .capture,
      .count_words, .start, .addr, .set_word, .done
   );

   drp_rmw_engine drp_rmw_engine_inst (
      .SCLK, .RST, .start, .addr, .set_word, .done,
      .DO, .DRDY, .DEN, .DWE, .DADDR, .DI
   );

endmodule

// File: test/pll_drp_sva.sv
`timescale 1ns/1ns

// drp port protocol rules, bound into the controller top
module pll_drp_sva (
   input logic SCLK,
   input logic RST,
   input logic DEN,
   input logic DWE,
   input logic DRDY,
   input logic SRDY,
   input logic RST_PLL
);

   logic open_txn;                            // DEN issued, DRDY not back yet

   always_ff @(posedge SCLK) begin
      if (RST) begin
         open_txn <= 1'b0;
      end else if (DEN) begin
         open_txn <= 1'b1;
      end else if (DRDY) begin
         open_txn <= 1'b0;
      end
   end

   // ********************
   // port rules
   // ********************
   dwe_only_with_den: assert property (@(posedge SCLK) disable iff (RST) DWE |-> DEN)
      else $error("DWE high without DEN");

   den_one_cycle: assert property (@(posedge SCLK) disable iff (RST) DEN |=> !DEN)
      else $error("DEN high for two cycles in a row");

   // only one access on the port at a time
   den_after_drdy: assert property (@(posedge SCLK) disable iff (RST) DEN |-> !open_txn)
      else $error("second DEN before DRDY");

   srdy_not_in_pll_reset: assert property (@(posedge SCLK) disable iff (RST) SRDY |-> !RST_PLL)
      else $error("SRDY while RST_PLL high");

endmodule

bind pll_drp_reconfig pll_drp_sva pll_drp_sva_inst (
   .SCLK, .RST, .DEN, .DWE, .DRDY, .SRDY, .RST_PLL
);

// File: test/pll_drp_tb.sv
`timescale 1ns/1ns
`include "pll_drp_consts.svh"

module pll_drp_tb;
   import pll_drp_pkg::*;

   localparam int clk_period     = 8;
   localparam int reset_cycles   = 10;
   localparam int max_vec        = 16;
   localparam int cycles_per_vec = `PLL_NUM_CLKOUT * 2 * (4 + 8);  // worst drdy + lock
   localparam int timeout_margin = 400;
   localparam drp_addr_t base_addr = `DRP_CLKOUT_BASE;

   logic        SCLK;
   logic        RST;
   logic        SEN;
   logic        LOCKED;
   logic        DRDY;
   drp_data_t   DO;
   clkout_div_t divs [`PLL_NUM_CLKOUT];
   logic        SRDY;
   logic        DWE;
   logic        DEN;
   drp_addr_t   DADDR;
   drp_data_t   DI;
   logic        DCLK;
   logic        RST_PLL;

   // pll model state
   drp_data_t   regs [32];
   drp_data_t   regs_before [32];
   logic [5:0]  txn_log [$];                  // {we, addr} per DEN
   integer      seed;
   bit          busy;                         // one access open
   bit          pend_we;
   drp_addr_t   pend_addr;
   int          drdy_wait;
   int          lock_wait;
   int          srdy_count;

   // test bookkeeping
   int          errors;
   int          tests_passed;
   int          tests_failed;
   int          vec_count;
   bit          loaded;
   logic [15:0] vec_words [max_vec][12];     // six divides, six expected regs

   pll_drp_reconfig pll_drp_reconfig_inst (
      .SCLK, .RST, .SEN, .SRDY,
      .clkout0_divide(divs[0]), .clkout1_divide(divs[1]), .clkout2_divide(divs[2]),
      .clkout3_divide(divs[3]), .clkout4_divide(divs[4]), .clkout5_divide(divs[5]),
      .DO, .DRDY, .LOCKED, .DWE, .DEN, .DADDR, .DI, .DCLK, .RST_PLL
   );

   always #(clk_period / 2) SCLK = ~SCLK;

   // ********************
   // pll model
   // ********************
   // all of it on the falling edge, DUT outputs are settled there
   always @(negedge SCLK) begin
      DRDY = 1'b0;                            // one cycle pulse
      if (busy) begin
         drdy_wait = drdy_wait - 1;
         if (drdy_wait == 0) begin
            DRDY = 1'b1;
            busy = 1'b0;
            if (!pend_we) DO = regs[pend_addr];
            if (RST_PLL !== 1'b1) begin
               $display("error: DRDY to addr %02h answered while RST_PLL was low", pend_addr);
               errors++;
            end
         end
      end
      if (DEN === 1'b1) begin
         if (busy) begin
            $display("error: DEN issued while an access to %02h was still open", pend_addr);
            errors++;
         end
         if (RST_PLL !== 1'b1) begin
            $display("error: DEN at addr %02h while RST_PLL was low", DADDR);
            errors++;
         end
         busy      = 1'b1;
         pend_we   = DWE;
         pend_addr = DADDR;
         drdy_wait = 1 + ($unsigned($random(seed)) % 4);   // 1..4 cycles
         txn_log.push_back({DWE, DADDR});
         if (DWE === 1'b1) regs[DADDR] = DI;
      end
      // lock drops with the pll reset, comes back 2..8 cycles after it
      if (RST_PLL !== 1'b0) begin
         LOCKED    = 1'b0;
         lock_wait = 2 + ($unsigned($random(seed)) % 7);
      end else if (!LOCKED) begin
         lock_wait = lock_wait - 1;
         if (lock_wait == 0) LOCKED = 1'b1;
      end
      if (SRDY === 1'b1) srdy_count++;
   end

   // ********************
   // helpers
   // ********************
   task load_stimulus();
      int fd;
      int n;
      int reg_lines;
      string line;
      logic [15:0] w [12];
      reg_lines = 0;
      vec_count = 0;
      fd = $fopen("test/pll_drp_stimulus.txt", "r");
      if (fd == 0) begin
         $display("error: test/pll_drp_stimulus.txt could not be opened");
         errors++;
         return;
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() < 4 || line[0] == "#") begin
            n = 0;                            // comment or blank line
         end else if (reg_lines < 4) begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                        w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
            if (n != 8) begin
               $display("error: register line %0d of the stimulus file is short", reg_lines);
               errors++;
            end
            for (int i = 0; i < 8; i++) regs[reg_lines * 8 + i] = w[i];
            reg_lines++;
         end else if (vec_count < max_vec) begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", w[0], w[1], w[2],
                        w[3], w[4], w[5], w[6], w[7], w[8], w[9], w[10], w[11]);
            if (n != 12) begin
               $display("error: vector line %0d of the stimulus file is short", vec_count);
               errors++;
            end
            for (int i = 0; i < 12; i++) vec_words[vec_count][i] = w[i];
            vec_count++;
         end
      end
      $fclose(fd);
   endtask

   task wait_rst_pll(input logic level);
      int n;
      n = 0;
      while (RST_PLL !== level && n < cycles_per_vec) begin
         @(negedge SCLK);
         n++;
      end
      if (RST_PLL !== level) begin
         $display("error: RST_PLL did not go to %0b within %0d cycles", level, n);
         errors++;
      end
   endtask

   task wait_srdy();
      int n;
      n = 0;
      while (SRDY !== 1'b1 && n < cycles_per_vec) begin
         @(negedge SCLK);
         n++;
      end
      if (SRDY !== 1'b1) begin
         $display("error: no SRDY pulse within %0d cycles", n);
         errors++;
      end
   endtask

   task report_test(input string name, input int err0);
      if (errors == err0) begin
         tests_passed++;
         $display("%s: pass", name);
      end else begin
         tests_failed++;
         $display("%s: fail with %0d errors", name, errors - err0);
      end
   endtask

   // ********************
   // tests
   // ********************
   task run_reset_test();
      int err0;
      err0 = errors;
      repeat (reset_cycles - 1) @(negedge SCLK);
      #(clk_period / 4);                      // middle of the low phase
      if (DCLK !== 1'b0) begin
         $display("FAIL DCLK: got 0x%h expected 0x0 with SCLK low", DCLK);
         errors++;
      end
      #(clk_period / 2);                      // middle of the high phase
      if (DCLK !== 1'b1) begin
         $display("FAIL DCLK: got 0x%h expected 0x1 with SCLK high", DCLK);
         errors++;
      end
      @(negedge SCLK);
      if (DEN !== 1'b0) begin
         $display("FAIL DEN: got 0x%h expected 0x0 in reset", DEN);
         errors++;
      end
      if (DWE !== 1'b0) begin
         $display("FAIL DWE: got 0x%h expected 0x0 in reset", DWE);
         errors++;
      end
      if (SRDY !== 1'b0) begin
         $display("FAIL SRDY: got 0x%h expected 0x0 in reset", SRDY);
         errors++;
      end
      if (RST_PLL !== 1'b1) begin
         $display("FAIL RST_PLL: got 0x%h expected 0x1 in reset", RST_PLL);
         errors++;
      end
      RST = 1'b0;
      @(negedge SCLK);
      if (RST_PLL !== 1'b0) begin
         $display("FAIL RST_PLL: got 0x%h expected 0x0 one cycle after reset", RST_PLL);
         errors++;
      end
      wait_srdy();
      if (LOCKED !== 1'b1) begin
         $display("error: SRDY came before LOCKED was high");
         errors++;
      end
      repeat (20) @(negedge SCLK);            // no second pulse may follow
      if (srdy_count != 1) begin
         $display("FAIL srdy_count: got 0x%h expected 0x1", srdy_count);
         errors++;
      end
      if (txn_log.size() != 0) begin
         $display("FAIL DEN count: got 0x%0h expected 0x0 before any SEN", txn_log.size());
         errors++;
      end
      report_test("reset and first lock", err0);
   endtask

   task run_vector(input int v);
      int err0;
      int srdy0;
      logic [15:0] exp;
      logic [5:0] rd_exp;
      logic [5:0] wr_exp;
      err0  = errors;
      srdy0 = srdy_count;
      txn_log.delete();
      regs_before = regs;
      for (int i = 0; i < `PLL_NUM_CLKOUT; i++) divs[i] = vec_words[v][i][7:0];
      SEN = 1'b1;
      @(negedge SCLK);
      SEN = 1'b0;
      wait_rst_pll(1'b1);
      repeat (10) @(negedge SCLK);
      SEN = 1'b1;                             // stray start mid walk
      @(negedge SCLK);
      SEN = 1'b0;
      wait_rst_pll(1'b0);
      for (int r = 0; r < 32; r++) begin
         if (r >= base_addr && r < base_addr + `PLL_NUM_CLKOUT) begin
            exp = vec_words[v][6 + r - base_addr];
         end else begin
            exp = regs_before[r];             // untouched by the walk
         end
         if (regs[r] !== exp) begin
            $display("FAIL regs[%02h]: got 0x%04h expected 0x%04h", r, regs[r], exp);
            errors++;
         end
      end
      if (txn_log.size() != 2 * `PLL_NUM_CLKOUT) begin
         $display("FAIL DEN count: got 0x%0h expected 0x%0h",
                  txn_log.size(), 2 * `PLL_NUM_CLKOUT);
         errors++;
      end else begin
         for (int i = 0; i < `PLL_NUM_CLKOUT; i++) begin
            rd_exp = {1'b0, base_addr + drp_addr_t'(i)};
            wr_exp = {1'b1, base_addr + drp_addr_t'(i)};
            if (txn_log[2 * i] !== rd_exp || txn_log[2 * i + 1] !== wr_exp) begin
               $display("FAIL {DWE,DADDR} pair %0d: got 0x%h 0x%h expected 0x%h 0x%h",
                        i, txn_log[2 * i], txn_log[2 * i + 1], rd_exp, wr_exp);
               errors++;
            end
         end
      end
      wait_srdy();
      repeat (4) @(negedge SCLK);
      if (srdy_count - srdy0 != 1) begin
         $display("FAIL srdy_count: got 0x%h expected 0x1 per vector", srdy_count - srdy0);
         errors++;
      end
      report_test($sformatf("vector %0d", v + 1), err0);
   endtask

   // ********************
   // main
   // ********************
   initial begin
      SCLK   = 1'b0;
      RST    = 1'b1;
      SEN    = 1'b0;
      LOCKED = 1'b0;
      DRDY   = 1'b0;
      DO     = '0;
      for (int i = 0; i < `PLL_NUM_CLKOUT; i++) divs[i] = '0;
      seed       = 32'hed1c5f4c;
      busy       = 1'b0;
      lock_wait  = 8;
      srdy_count = 0;
      errors     = 0;
      tests_passed = 0;
      tests_failed = 0;
      for (int r = 0; r < 32; r++) regs[r] = '0;
      load_stimulus();
      loaded = 1'b1;
      run_reset_test();
      for (int v = 0; v < vec_count; v++) run_vector(v);
      $display("summary: %0d tests passed, %0d tests failed, %0d errors",
               tests_passed, tests_failed, errors);
      if (errors == 0 && tests_failed == 0 && vec_count > 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // watchdog sized from the vector count
   initial begin
      int limit;
      wait (loaded);
      limit = vec_count * cycles_per_vec + reset_cycles + timeout_margin;
      repeat (limit) @(posedge SCLK);
      $display("watchdog: run timed out after %0d cycles", limit);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// File: test/pll_drp_stimulus.txt
# pll drp reconfiguration stimulus, all values hex
# first four data lines: initial drp registers 00..1f, eight 16-bit words per line
# each later line is one vector:
#   clkout0..clkout5 divide, then expected registers 08..0d after the walk
# expected = (old value & c000) | count word
# count word: [5:0] low, [11:6] high, [12] nocount, [13] edge
3000 3101 3202 3303 3404 3505 3606 3707
c808 4909 8a0a fb0b 7c0c bd0d 3e0e 3f0f
4010 4111 4212 4313 4414 4515 4616 4717
4818 4919 4a1a 4b1b 4c1c 4d1d 4e1e 4f1f
# corners: 0 runs as 1, 1 sets nocount, 3 sets edge, 200 saturates to 126
00 01 02 03 c8 0a  d041 5041 8041 e042 4fff 8145
# 126 and 127 and 255 all give 126, odd 5 and 99 set edge
7e 7f 05 40 63 ff  cfff 4fff a083 c820 6c72 8fff
# mixed odd and even, second divide of 1
07 04 01 09 21 02  e0c4 4082 9041 e105 6411 8041

// File: sim.f
+incdir+hw
hw/pll_drp_pkg.sv
hw/clkout_count_encoder.sv
hw/drp_rmw_sequencer.sv
hw/drp_rmw_engine.sv
hw/pll_drp_reconfig.sv
test/pll_drp_sva.sv
test/pll_drp_tb.sv

// File: Bender.yml
package:
  name: pll_drp_reconfig

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/pll_drp_pkg.sv
      - hw/clkout_count_encoder.sv
      - hw/drp_rmw_sequencer.sv
      - hw/drp_rmw_engine.sv
      - hw/pll_drp_reconfig.sv

  - target: test
    include_dirs:
      - hw
    files:
      - test/pll_drp_sva.sv
      - test/pll_drp_tb.sv
